/* source/udp_mux_defines.svh */
/*
 * UDP arbitrated mux sizing
 * Source count, payload width and source index width shared by the design.
 */
`ifndef UDP_MUX_DEFINES_SVH
`define UDP_MUX_DEFINES_SVH

// number of frame sources
`define UDP_MUX_S_COUNT 4

// payload stream width, one byte per beat
`define UDP_MUX_DATA_WIDTH 8

// bits needed to index a source
`define UDP_MUX_SEL_WIDTH 2

`endif

/* source/udp_hdr_pkg.sv */
/*
 * UDP header types
 * The subset of the UDP/IP header that travels through the mux.
 * 112 bits, addresses first.
 */
package udp_hdr_pkg;

    // carried header fields
    typedef struct packed {
        logic [31:0] ip_source_ip;
        logic [31:0] ip_dest_ip;
        logic [15:0] udp_source_port;
        logic [15:0] udp_dest_port;
        // payload length in bytes plus the udp header
        logic [15:0] udp_length;
    } udp_hdr_t;

endpackage

/* source/udp_stream_pkg.sv */
/*
 * UDP payload stream types
 * Payload beat layout and the source index used by the arbiter.
 */
`include "udp_mux_defines.svh"

package udp_stream_pkg;

    // one payload byte plus end of frame
    typedef struct packed {
        logic [`UDP_MUX_DATA_WIDTH-1:0] data;
        logic                           last;
    } payload_beat_t;

    // binary index of a source
    typedef logic [`UDP_MUX_SEL_WIDTH-1:0] src_index_t;

endpackage

/* source/udp_beat_if.sv */
/*
 * Payload beat interface
 * Carries the steered payload from the frame selector to the output stage.
 */
interface udp_beat_if;

    udp_stream_pkg::payload_beat_t beat;
    // already qualified by ready
    logic                          valid;
    // registered in the consumer
    logic                          ready;

    modport producer (
        output beat,
        output valid,
        input  ready
    );

    modport consumer (
        input  beat,
        input  valid,
        output ready
    );

endinterface

/* source/udp_rr_arbiter.sv */
/*
 * Round-robin arbiter
 * Registered one-hot grant with its index, held until the granted source
 * acknowledges. Lowest index wins first after reset.
 */
`include "udp_mux_defines.svh"

module udp_rr_arbiter (
    input  logic                             clk,
    input  logic                             rst,
    input  logic [`UDP_MUX_S_COUNT-1:0]     request,
    input  logic [`UDP_MUX_S_COUNT-1:0]     acknowledge,
    output logic [`UDP_MUX_S_COUNT-1:0]     grant,
    output logic                             grant_valid,
    output udp_stream_pkg::src_index_t       grant_index
);

    logic [`UDP_MUX_S_COUNT-1:0] mask_reg;
    logic [`UDP_MUX_S_COUNT-1:0] mask_next;
    logic [`UDP_MUX_S_COUNT-1:0] masked_request;
    logic [`UDP_MUX_S_COUNT-1:0] grant_next;
    logic                        grant_valid_next;
    udp_stream_pkg::src_index_t  grant_index_next;
    udp_stream_pkg::src_index_t  pick_index;

    // lowest set bit of a request vector
    function automatic udp_stream_pkg::src_index_t lowest_index(
        input logic [`UDP_MUX_S_COUNT-1:0] vec
    );
        udp_stream_pkg::src_index_t idx;
        idx = '0;
        for (int i = `UDP_MUX_S_COUNT - 1; i >= 0; i--) begin
            if (vec[i]) begin
                idx = udp_stream_pkg::src_index_t'(i);
            end
        end
        return idx;
    endfunction

    // requests above the last grant go first
    assign masked_request = request & ~mask_reg;
    assign pick_index = (|masked_request) ? lowest_index(masked_request)
                                          : lowest_index(request);

    always_comb begin
        grant_next = grant;
        grant_valid_next = grant_valid;
        grant_index_next = grant_index;
        mask_next = mask_reg;

        if (grant_valid) begin
            // hold until the granted source closes its frame
            if (|(grant & acknowledge)) begin
                grant_next = '0;
                grant_valid_next = 1'b0;
            end
        end else if (|request) begin
            grant_next = {{(`UDP_MUX_S_COUNT-1){1'b0}}, 1'b1} << pick_index;
            grant_valid_next = 1'b1;
            grant_index_next = pick_index;
            // the new winner and everything below it wait a turn
            for (int i = 0; i < `UDP_MUX_S_COUNT; i++) begin
                mask_next[i] = (i <= int'(pick_index));
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            grant <= '0;
            grant_valid <= 1'b0;
            grant_index <= '0;
            mask_reg <= '0;
        end else begin
            grant <= grant_next;
            grant_valid <= grant_valid_next;
            grant_index <= grant_index_next;
            mask_reg <= mask_next;
        end
    end

endmodule

/* source/udp_frame_select.sv */
/*
 * Frame selector
 * Tracks the open frame of the granted source, captures its header onto the
 * output register and steers its payload into the beat interface.
 */
`include "udp_mux_defines.svh"

module udp_frame_select (
    input  logic                                      clk,
    input  logic                                      rst,
    input  logic [`UDP_MUX_S_COUNT-1:0]              grant,
    input  logic                                      grant_valid,
    input  udp_stream_pkg::src_index_t                grant_index,
    output logic [`UDP_MUX_S_COUNT-1:0]              request,
    output logic [`UDP_MUX_S_COUNT-1:0]              acknowledge,
    input  logic [`UDP_MUX_S_COUNT-1:0]              s_hdr_valid,
    output logic [`UDP_MUX_S_COUNT-1:0]              s_hdr_ready,
    input  logic [`UDP_MUX_S_COUNT*32-1:0]           s_ip_source_ip,
    input  logic [`UDP_MUX_S_COUNT*32-1:0]           s_ip_dest_ip,
    input  logic [`UDP_MUX_S_COUNT*16-1:0]           s_udp_source_port,
    input  logic [`UDP_MUX_S_COUNT*16-1:0]           s_udp_dest_port,
    input  logic [`UDP_MUX_S_COUNT*16-1:0]           s_udp_length,
    input  logic [`UDP_MUX_S_COUNT*`UDP_MUX_DATA_WIDTH-1:0] s_payload_tdata,
    input  logic [`UDP_MUX_S_COUNT-1:0]              s_payload_tvalid,
    output logic [`UDP_MUX_S_COUNT-1:0]              s_payload_tready,
    input  logic [`UDP_MUX_S_COUNT-1:0]              s_payload_tlast,
    output logic                                      m_hdr_valid,
    input  logic                                      m_hdr_ready,
    output udp_hdr_pkg::udp_hdr_t                     m_hdr,
    udp_beat_if.producer                              beat_out
);

    logic                  frame_reg;
    logic                  frame_next;
    logic                  hdr_mask_reg;
    logic                  hdr_mask_next;
    logic                  m_hdr_valid_next;
    logic                  load_hdr;
    udp_hdr_pkg::udp_hdr_t sel_hdr;

    // a granted source stops requesting
    assign request = s_hdr_valid & ~grant;
    assign acknowledge = grant & s_payload_tvalid & s_payload_tready & s_payload_tlast;

    // one-cycle header ready at the start of the grant
    assign s_hdr_ready = {{(`UDP_MUX_S_COUNT-1){1'b0}}, !hdr_mask_reg && grant_valid}
                         << grant_index;
    assign s_payload_tready = {{(`UDP_MUX_S_COUNT-1){1'b0}}, beat_out.ready && grant_valid}
                              << grant_index;

    // header fields of the granted source
    always_comb begin
        sel_hdr.ip_source_ip = s_ip_source_ip[grant_index*32 +: 32];
        sel_hdr.ip_dest_ip = s_ip_dest_ip[grant_index*32 +: 32];
        sel_hdr.udp_source_port = s_udp_source_port[grant_index*16 +: 16];
        sel_hdr.udp_dest_port = s_udp_dest_port[grant_index*16 +: 16];
        sel_hdr.udp_length = s_udp_length[grant_index*16 +: 16];
    end

    // payload steering
    assign beat_out.beat = '{
        data: s_payload_tdata[grant_index*`UDP_MUX_DATA_WIDTH +: `UDP_MUX_DATA_WIDTH],
        last: s_payload_tlast[grant_index]
    };
    assign beat_out.valid = s_payload_tvalid[grant_index] && beat_out.ready && grant_valid;

    always_comb begin
        frame_next = frame_reg;
        hdr_mask_next = hdr_mask_reg;
        m_hdr_valid_next = m_hdr_valid && !m_hdr_ready;
        load_hdr = 1'b0;

        if (!frame_reg && grant_valid) begin
            // start of frame overwrites an unaccepted header
            frame_next = 1'b1;
            hdr_mask_next = 1'b1;
            m_hdr_valid_next = 1'b1;
            load_hdr = 1'b1;
        end

        // last beat closes the frame even in the cycle it opened
        if (beat_out.valid && beat_out.beat.last) begin
            frame_next = 1'b0;
            hdr_mask_next = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            frame_reg <= 1'b0;
            hdr_mask_reg <= 1'b0;
            m_hdr_valid <= 1'b0;
        end else begin
            frame_reg <= frame_next;
            hdr_mask_reg <= hdr_mask_next;
            m_hdr_valid <= m_hdr_valid_next;
        end
    end

    always_ff @(posedge clk) begin
        if (load_hdr) begin
            m_hdr <= sel_hdr;
        end
    end

endmodule

/* source/udp_payload_skid.sv */
/*
 * Payload output stage
 * Output register plus one temporary register, so the input ready can be
 * registered without losing a beat under back-pressure.
 */
`include "udp_mux_defines.svh"

module udp_payload_skid (
    input  logic                           clk,
    input  logic                           rst,
    udp_beat_if.consumer                   beat_in,
    output logic [`UDP_MUX_DATA_WIDTH-1:0] m_payload_tdata,
    output logic                           m_payload_tvalid,
    output logic                           m_payload_tlast,
    input  logic                           m_payload_tready
);

    udp_stream_pkg::payload_beat_t out_reg;
    udp_stream_pkg::payload_beat_t temp_reg;
    logic                          out_valid_reg;
    logic                          out_valid_next;
    logic                          temp_valid_reg;
    logic                          temp_valid_next;
    logic                          ready_reg;
    logic                          ready_early;
    logic                          store_in_to_out;
    logic                          store_in_to_temp;
    logic                          store_temp_to_out;

    assign beat_in.ready = ready_reg;

    assign m_payload_tdata = out_reg.data;
    assign m_payload_tlast = out_reg.last;
    assign m_payload_tvalid = out_valid_reg;

    // ready next cycle if the sink takes data or temp stays empty
    assign ready_early = m_payload_tready ||
                         (!temp_valid_reg && (!out_valid_reg || !beat_in.valid));

    always_comb begin
        out_valid_next = out_valid_reg;
        temp_valid_next = temp_valid_reg;
        store_in_to_out = 1'b0;
        store_in_to_temp = 1'b0;
        store_temp_to_out = 1'b0;

        if (ready_reg) begin
            if (m_payload_tready || !out_valid_reg) begin
                // input goes straight to the free output
                out_valid_next = beat_in.valid;
                store_in_to_out = 1'b1;
            end else begin
                // park the input while the output stalls
                temp_valid_next = beat_in.valid;
                store_in_to_temp = 1'b1;
            end
        end else if (m_payload_tready) begin
            // drain the parked beat
            out_valid_next = temp_valid_reg;
            temp_valid_next = 1'b0;
            store_temp_to_out = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid_reg <= 1'b0;
            temp_valid_reg <= 1'b0;
            ready_reg <= 1'b0;
        end else begin
            out_valid_reg <= out_valid_next;
            temp_valid_reg <= temp_valid_next;
            ready_reg <= ready_early;
        end
    end

    // datapath
    always_ff @(posedge clk) begin
        if (store_in_to_out) begin
            out_reg <= beat_in.beat;
        end else if (store_temp_to_out) begin
            out_reg <= temp_reg;
        end

        if (store_in_to_temp) begin
            temp_reg <= beat_in.beat;
        end
    end

endmodule

/* source/udp_arb_mux.sv */
/*
 * UDP arbitrated multiplexer
 * Four header plus payload sources share one output, granted round-robin
 * one whole frame at a time.
 */
`include "udp_mux_defines.svh"

module udp_arb_mux (
    input  logic                                      clk,
    input  logic                                      rst,
    input  logic [`UDP_MUX_S_COUNT-1:0]              s_hdr_valid,
    output logic [`UDP_MUX_S_COUNT-1:0]              s_hdr_ready,
    input  logic [`UDP_MUX_S_COUNT*32-1:0]           s_ip_source_ip,
    input  logic [`UDP_MUX_S_COUNT*32-1:0]           s_ip_dest_ip,
    input  logic [`UDP_MUX_S_COUNT*16-1:0]           s_udp_source_port,
    input  logic [`UDP_MUX_S_COUNT*16-1:0]           s_udp_dest_port,
    input  logic [`UDP_MUX_S_COUNT*16-1:0]           s_udp_length,
    input  logic [`UDP_MUX_S_COUNT*`UDP_MUX_DATA_WIDTH-1:0] s_payload_tdata,
    input  logic [`UDP_MUX_S_COUNT-1:0]              s_payload_tvalid,
    output logic [`UDP_MUX_S_COUNT-1:0]              s_payload_tready,
    input  logic [`UDP_MUX_S_COUNT-1:0]              s_payload_tlast,
    output logic                                      m_hdr_valid,
    input  logic                                      m_hdr_ready,
    output logic [31:0]                               m_ip_source_ip,
    output logic [31:0]                               m_ip_dest_ip,
    output logic [15:0]                               m_udp_source_port,
    output logic [15:0]                               m_udp_dest_port,
    output logic [15:0]                               m_udp_length,
    output logic [`UDP_MUX_DATA_WIDTH-1:0]           m_payload_tdata,
    output logic                                      m_payload_tvalid,
    input  logic                                      m_payload_tready,
    output logic                                      m_payload_tlast
);

    logic [`UDP_MUX_S_COUNT-1:0] request;
    logic [`UDP_MUX_S_COUNT-1:0] acknowledge;
    logic [`UDP_MUX_S_COUNT-1:0] grant;
    logic                        grant_valid;
    udp_stream_pkg::src_index_t  grant_index;
    udp_hdr_pkg::udp_hdr_t       m_hdr;

    udp_beat_if beat_if ();

    assign m_ip_source_ip = m_hdr.ip_source_ip;
    assign m_ip_dest_ip = m_hdr.ip_dest_ip;
    assign m_udp_source_port = m_hdr.udp_source_port;
    assign m_udp_dest_port = m_hdr.udp_dest_port;
    assign m_udp_length = m_hdr.udp_length;

    udp_rr_arbiter u_arbiter (
        .clk         (clk),
        .rst         (rst),
        .request     (request),
        .acknowledge (acknowledge),
        .grant       (grant),
        .grant_valid (grant_valid),
        .grant_index (grant_index)
    );

    udp_frame_select u_frame_select (
        .clk               (clk),
        .rst               (rst),
        .grant             (grant),
        .grant_valid       (grant_valid),
        .grant_index       (grant_index),
        .request           (request),
        .acknowledge       (acknowledge),
        .s_hdr_valid       (s_hdr_valid),
        .s_hdr_ready       (s_hdr_ready),
        .s_ip_source_ip    (s_ip_source_ip),
        .s_ip_dest_ip      (s_ip_dest_ip),
        .s_udp_source_port (s_udp_source_port),
        .s_udp_dest_port   (s_udp_dest_port),
        .s_udp_length      (s_udp_length),
        .s_payload_tdata   (s_payload_tdata),
        .s_payload_tvalid  (s_payload_tvalid),
        .s_payload_tready  (s_payload_tready),
        .s_payload_tlast   (s_payload_tlast),
        .m_hdr_valid       (m_hdr_valid),
        .m_hdr_ready       (m_hdr_ready),
        .m_hdr             (m_hdr),
        .beat_out          (beat_if.producer)
    );

    udp_payload_skid u_payload_skid (
        .clk              (clk),
        .rst              (rst),
        .beat_in          (beat_if.consumer),
        .m_payload_tdata  (m_payload_tdata),
        .m_payload_tvalid (m_payload_tvalid),
        .m_payload_tlast  (m_payload_tlast),
        .m_payload_tready (m_payload_tready)
    );

endmodule

/* sim/udp_arb_mux_chk.sv */
/*
 * UDP arbitrated mux checker
 * Bound into the mux top level. Checks reset state, exclusive readiness,
 * header passthrough, payload order, output stability and round-robin order.
 */
`include "udp_mux_defines.svh"

module udp_arb_mux_chk (
    input logic                                      clk,
    input logic                                      rst,
    input logic [`UDP_MUX_S_COUNT-1:0]              s_hdr_valid,
    input logic [`UDP_MUX_S_COUNT-1:0]              s_hdr_ready,
    input logic [`UDP_MUX_S_COUNT*32-1:0]           s_ip_source_ip,
    input logic [`UDP_MUX_S_COUNT*32-1:0]           s_ip_dest_ip,
    input logic [`UDP_MUX_S_COUNT*16-1:0]           s_udp_source_port,
    input logic [`UDP_MUX_S_COUNT*16-1:0]           s_udp_dest_port,
    input logic [`UDP_MUX_S_COUNT*16-1:0]           s_udp_length,
    input logic [`UDP_MUX_S_COUNT*`UDP_MUX_DATA_WIDTH-1:0] s_payload_tdata,
    input logic [`UDP_MUX_S_COUNT-1:0]              s_payload_tvalid,
    input logic [`UDP_MUX_S_COUNT-1:0]              s_payload_tready,
    input logic [`UDP_MUX_S_COUNT-1:0]              s_payload_tlast,
    input logic                                      m_hdr_valid,
    input logic [31:0]                               m_ip_source_ip,
    input logic [31:0]                               m_ip_dest_ip,
    input logic [15:0]                               m_udp_source_port,
    input logic [15:0]                               m_udp_dest_port,
    input logic [15:0]                               m_udp_length,
    input logic [`UDP_MUX_DATA_WIDTH-1:0]           m_payload_tdata,
    input logic                                      m_payload_tvalid,
    input logic                                      m_payload_tready,
    input logic                                      m_payload_tlast
);

    udp_stream_pkg::src_index_t    hdr_idx;
    udp_stream_pkg::src_index_t    in_idx;
    udp_stream_pkg::src_index_t    last_idx;
    logic                          last_seen;
    logic                          hdr_take;
    logic                          in_take;
    logic [`UDP_MUX_S_COUNT-1:0]  owner_bit;
    udp_hdr_pkg::udp_hdr_t         exp_hdr;
    udp_stream_pkg::payload_beat_t exp_beats [0:63];
    udp_stream_pkg::payload_beat_t exp_head;
    logic [5:0]                    wr_ptr;
    logic [5:0]                    rd_ptr;

    // readiness is one-hot, so the ready bit names the source
    always_comb begin
        hdr_idx = '0;
        in_idx = '0;
        for (int i = 0; i < `UDP_MUX_S_COUNT; i++) begin
            if (s_hdr_ready[i]) begin
                hdr_idx = udp_stream_pkg::src_index_t'(i);
            end
            if (s_payload_tready[i]) begin
                in_idx = udp_stream_pkg::src_index_t'(i);
            end
        end
    end

    assign hdr_take = |(s_hdr_valid & s_hdr_ready);
    assign in_take = |(s_payload_tvalid & s_payload_tready);
    assign exp_head = exp_beats[rd_ptr];

    always_ff @(posedge clk) begin
        if (rst) begin
            owner_bit <= '0;
            last_seen <= 1'b0;
            last_idx <= '0;
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (hdr_take) begin
                owner_bit <= s_hdr_valid & s_hdr_ready;
                last_seen <= 1'b1;
                last_idx <= hdr_idx;
                exp_hdr.ip_source_ip <= s_ip_source_ip[hdr_idx*32 +: 32];
                exp_hdr.ip_dest_ip <= s_ip_dest_ip[hdr_idx*32 +: 32];
                exp_hdr.udp_source_port <= s_udp_source_port[hdr_idx*16 +: 16];
                exp_hdr.udp_dest_port <= s_udp_dest_port[hdr_idx*16 +: 16];
                exp_hdr.udp_length <= s_udp_length[hdr_idx*16 +: 16];
            end else if (in_take && s_payload_tlast[in_idx]) begin
                owner_bit <= '0;
            end
            // reference queue of accepted input beats
            if (in_take) begin
                exp_beats[wr_ptr] <= '{
                    data: s_payload_tdata[in_idx*`UDP_MUX_DATA_WIDTH +: `UDP_MUX_DATA_WIDTH],
                    last: s_payload_tlast[in_idx]
                };
                wr_ptr <= wr_ptr + 6'd1;
            end
            if (m_payload_tvalid && m_payload_tready) begin
                rd_ptr <= rd_ptr + 6'd1;
            end
        end
    end

    reset_state: assert property (@(posedge clk)
        rst |=> (!m_hdr_valid && !m_payload_tvalid &&
                 s_hdr_ready == '0 && s_payload_tready == '0))
        else $error("mux outputs or source readies not idle after reset");

    one_ready: assert property (@(posedge clk) disable iff (rst)
        $onehot0(s_hdr_ready) && $onehot0(s_payload_tready))
        else $error("more than one source ready at the same time");

    frame_owner: assert property (@(posedge clk) disable iff (rst)
        (|owner_bit) |-> (((s_hdr_ready | s_payload_tready) & ~owner_bit) == '0))
        else $error("another source became ready during an open frame");

    header_pass: assert property (@(posedge clk) disable iff (rst)
        hdr_take |=> (m_hdr_valid &&
                      {m_ip_source_ip, m_ip_dest_ip, m_udp_source_port,
                       m_udp_dest_port, m_udp_length} == exp_hdr))
        else $error("output header differs from the accepted source header");

    payload_order: assert property (@(posedge clk) disable iff (rst)
        (m_payload_tvalid && m_payload_tready) |->
            (rd_ptr != wr_ptr && m_payload_tdata == exp_head.data &&
             m_payload_tlast == exp_head.last))
        else $error("output payload beat lost, reordered or corrupted");

    output_hold: assert property (@(posedge clk) disable iff (rst)
        (m_payload_tvalid && !m_payload_tready) |=>
            (m_payload_tvalid && $stable(m_payload_tdata) && $stable(m_payload_tlast)))
        else $error("stalled output beat changed");

    // all four waiting at the grant decision means strict rotation
    rr_order: assert property (@(posedge clk) disable iff (rst)
        (hdr_take && last_seen && $past(s_hdr_valid) == '1) |->
            (hdr_idx == last_idx + 2'd1))
        else $error("header grant broke the round-robin order");

endmodule

bind udp_arb_mux udp_arb_mux_chk u_chk (.*);

/* sim/udp_arb_mux_tb.sv */
/*
 * Testbench for the UDP arbitrated mux
 * Four sources send frames of random length under random output stalls.
 * Frames sent and frames delivered are counted and compared at the end.
 */
`include "udp_mux_defines.svh"

module udp_arb_mux_tb;

    localparam int FRAMES_PER_SOURCE = 12;
    localparam int HDR_TIMEOUT = 1000;
    localparam int BEAT_TIMEOUT = 200;
    localparam int DRAIN_TIMEOUT = 500;

    logic                                      clk;
    logic                                      rst;
    logic [`UDP_MUX_S_COUNT-1:0]              s_hdr_valid;
    logic [`UDP_MUX_S_COUNT-1:0]              s_hdr_ready;
    logic [`UDP_MUX_S_COUNT*32-1:0]           s_ip_source_ip;
    logic [`UDP_MUX_S_COUNT*32-1:0]           s_ip_dest_ip;
    logic [`UDP_MUX_S_COUNT*16-1:0]           s_udp_source_port;
    logic [`UDP_MUX_S_COUNT*16-1:0]           s_udp_dest_port;
    logic [`UDP_MUX_S_COUNT*16-1:0]           s_udp_length;
    logic [`UDP_MUX_S_COUNT*`UDP_MUX_DATA_WIDTH-1:0] s_payload_tdata;
    logic [`UDP_MUX_S_COUNT-1:0]              s_payload_tvalid;
    logic [`UDP_MUX_S_COUNT-1:0]              s_payload_tready;
    logic [`UDP_MUX_S_COUNT-1:0]              s_payload_tlast;
    logic                                      m_hdr_valid;
    logic                                      m_hdr_ready;
    logic [31:0]                               m_ip_source_ip;
    logic [31:0]                               m_ip_dest_ip;
    logic [15:0]                               m_udp_source_port;
    logic [15:0]                               m_udp_dest_port;
    logic [15:0]                               m_udp_length;
    logic [`UDP_MUX_DATA_WIDTH-1:0]           m_payload_tdata;
    logic                                      m_payload_tvalid;
    logic                                      m_payload_tready;
    logic                                      m_payload_tlast;

    int seed;
    int tx_frames;
    int rx_frames;

    udp_arb_mux u_dut (.*);

    // non-negative random value below n
    function automatic int rand_below(input int n);
        int r;
        r = $random(seed) & 32'h7fff_ffff;
        return r % n;
    endfunction

    task automatic abort_on_timeout(input string what);
        $display("timeout: %s", what);
        $display("Done: errors found");
        $fatal(1, "simulation stopped after a timeout");
    endtask

    // header, then 1 to 6 payload bytes tagged with source and byte count
    task automatic send_frame(input int src, input int frame_no, inout int byte_count);
        int len;
        int cycles;
        len = 1 + rand_below(6);
        s_hdr_valid[src] <= 1'b1;
        s_ip_source_ip[src*32 +: 32] <= {8'd10, 8'd0, 8'(src), 8'(frame_no)};
        s_ip_dest_ip[src*32 +: 32] <= {8'd10, 8'd1, 8'(frame_no), 8'(src)};
        s_udp_source_port[src*16 +: 16] <= 16'(4000 + src);
        s_udp_dest_port[src*16 +: 16] <= 16'(5000 + frame_no);
        s_udp_length[src*16 +: 16] <= 16'(8 + len);
        cycles = 0;
        @(negedge clk);
        while (!s_hdr_ready[src] && cycles < HDR_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (!s_hdr_ready[src]) begin
            abort_on_timeout($sformatf("header of source %0d was never accepted", src));
        end
        @(posedge clk);
        s_hdr_valid[src] <= 1'b0;
        for (int b = 0; b < len; b++) begin
            s_payload_tvalid[src] <= 1'b1;
            s_payload_tdata[src*8 +: 8] <= {2'(src), 6'(byte_count)};
            s_payload_tlast[src] <= (b == len - 1);
            byte_count++;
            cycles = 0;
            @(negedge clk);
            while (!s_payload_tready[src] && cycles < BEAT_TIMEOUT) begin
                @(negedge clk);
                cycles++;
            end
            if (!s_payload_tready[src]) begin
                abort_on_timeout($sformatf("payload of source %0d was never accepted", src));
            end
            @(posedge clk);
        end
        s_payload_tvalid[src] <= 1'b0;
        s_payload_tlast[src] <= 1'b0;
        tx_frames++;
    endtask

    task automatic run_source(input int src);
        int byte_count;
        byte_count = 0;
        for (int f = 0; f < FRAMES_PER_SOURCE; f++) begin
            send_frame(src, f, byte_count);
            repeat (rand_below(4)) @(posedge clk);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // output stalls on about one cycle in four
    initial begin
        m_payload_tready = 1'b0;
        forever begin
            @(posedge clk);
            m_payload_tready <= (rand_below(4) != 0);
        end
    end

    always @(negedge clk) begin
        if (rst) begin
            rx_frames <= 0;
        end else if (m_payload_tvalid && m_payload_tready && m_payload_tlast) begin
            rx_frames <= rx_frames + 1;
        end
    end

    initial begin
        int cycles;
        seed = 90;
        tx_frames = 0;
        rst = 1'b1;
        s_hdr_valid = '0;
        s_ip_source_ip = '0;
        s_ip_dest_ip = '0;
        s_udp_source_port = '0;
        s_udp_dest_port = '0;
        s_udp_length = '0;
        s_payload_tdata = '0;
        s_payload_tvalid = '0;
        s_payload_tlast = '0;
        m_hdr_ready = 1'b1;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        // all sources start together, so the first round goes 0 to 3
        fork
            run_source(0);
            run_source(1);
            run_source(2);
            run_source(3);
        join
        cycles = 0;
        while (rx_frames < tx_frames && cycles < DRAIN_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (rx_frames < tx_frames) begin
            abort_on_timeout("the output did not deliver every frame");
        end
        repeat (4) @(posedge clk);
        if (rx_frames != tx_frames) begin
            $display("FAIL frame_count: expected %0d, actual %0d", tx_frames, rx_frames);
            $display("Done: errors found");
            $fatal(1, "frame count mismatch");
        end else begin
            $display("Done: no errors");
            $finish;
        end
    end

endmodule

/* udp_arb_mux.f */
+incdir+source
source/udp_hdr_pkg.sv
source/udp_stream_pkg.sv
source/udp_beat_if.sv
source/udp_rr_arbiter.sv
source/udp_frame_select.sv
source/udp_payload_skid.sv
source/udp_arb_mux.sv
sim/udp_arb_mux_chk.sv
sim/udp_arb_mux_tb.sv

/* Makefile */
VERILATOR  := verilator
TOP        := udp_arb_mux_tb
LINT_TOP   := udp_arb_mux
FILELIST   := udp_arb_mux.f
BUILD_DIR  := obj_dir
SIM_FLAGS  := --binary --timing --assert -j 0 -Mdir $(BUILD_DIR)
LINT_FLAGS := --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
